//--- seq_pkg.sv
// Shared sizes, unit indices and queue depths, imported by every sequencer block and the testbench
package seq_pkg;

  ////////////////////////////////////////
  // Instruction IDs
  ////////////////////////////////////////

  // Number of vector instructions that can be in flight at once
  localparam int unsigned NR_VINSN = 8;
  // One ID per in-flight instruction
  localparam int unsigned VID_W = 3;

  ////////////////////////////////////////
  // Vector register file
  ////////////////////////////////////////

  // Architectural vector registers tracked by the scoreboard
  localparam int unsigned NR_VREGS = 32;
  localparam int unsigned VREG_W = 5;

  ////////////////////////////////////////
  // Execution units
  ////////////////////////////////////////

  localparam int unsigned NR_UNITS = 4;
  localparam int unsigned UNIT_W = 2;

  // Unit indices, also the bit positions of the done and ready vectors
  localparam logic [UNIT_W-1:0] UNIT_ALU = 2'd0;
  localparam logic [UNIT_W-1:0] UNIT_MUL = 2'd1;
  localparam logic [UNIT_W-1:0] UNIT_LOAD = 2'd2;
  localparam logic [UNIT_W-1:0] UNIT_STORE = 2'd3;

  // Width of the per-unit occupancy counters, wide enough for the deepest queue
  localparam int unsigned CNT_W = 3;

  // Instruction queue depth of each unit
  // The concatenation lists the store unit first and the ALU last, so that
  // element 0 belongs to the ALU
  localparam logic [NR_UNITS-1:0][CNT_W-1:0] QUEUE_DEPTH = {
    CNT_W'(2),
    CNT_W'(2),
    CNT_W'(2),
    CNT_W'(4)
  };

endpackage : seq_pkg

//--- seq_issue_if.sv
// Accepted-instruction event, driven by the issue controller and watched by the bookkeeping blocks
`timescale 1ns/1ns

interface seq_issue_if;

  import seq_pkg::*;

  // Single-cycle pulse in the cycle where the dispatcher handshake completes
  logic accept;

  // Target execution unit of the instruction on the bus
  logic [UNIT_W-1:0] unit;

  // First source operand and whether the instruction reads it
  logic [VREG_W-1:0] vs1;
  logic use_vs1;

  // Second source operand
  logic [VREG_W-1:0] vs2;
  logic use_vs2;

  // Destination register, valid only with use_vd
  logic [VREG_W-1:0] vd;
  logic use_vd;

  // The issue controller owns the event and the instruction fields
  modport ctrl (
    output accept, unit, vs1, use_vs1, vs2, use_vs2, vd, use_vd
  );

  // Trackers, counters and the scoreboard only observe it
  // The fields are valid in every cycle, accept tells when they commit
  modport sink (
    input accept, unit, vs1, use_vs1, vs2, use_vs2, vd, use_vd
  );

endinterface : seq_issue_if

//--- insn_tracker.sv
// Hands out the lowest free instruction ID and tracks which ID runs on which unit until done
`timescale 1ns/1ns

module insn_tracker (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  seq_issue_if.sink                                         issue,
  input  logic [seq_pkg::NR_UNITS-1:0]                      unit_done_i,
  input  logic [seq_pkg::NR_UNITS-1:0][seq_pkg::VID_W-1:0]  unit_done_id_i,
  output logic [seq_pkg::VID_W-1:0]                         next_id_o,
  output logic                                              id_full_o,
  output logic [seq_pkg::NR_VINSN-1:0]                      running_o,
  output logic                                              idle_o
);

  import seq_pkg::*;

  // One row per unit, a set bit marks an ID that still runs on that unit
  logic [NR_UNITS-1:0][NR_VINSN-1:0] running_d, running_q;

  ////////////////////////////////////////
  // Free ID search
  ////////////////////////////////////////

  // An ID is busy if any unit still holds it
  always_comb begin
    running_o = '0;
    for (int unsigned u = 0; u < NR_UNITS; u++) begin
      running_o |= running_q[u];
    end
  end

  // Zero search over the busy vector from the top down, so the lowest free index wins
  always_comb begin
    next_id_o = '0;
    for (int i = NR_VINSN - 1; i >= 0; i--) begin
      if (!running_o[i]) next_id_o = VID_W'(i);
    end
  end

  assign id_full_o = &running_o;
  assign idle_o    = ~|running_o;

  ////////////////////////////////////////
  // Running table update
  ////////////////////////////////////////

  always_comb begin
    running_d = running_q;
    // Done pulses retire their ID on the reporting unit
    for (int unsigned u = 0; u < NR_UNITS; u++) begin
      if (unit_done_i[u]) running_d[u][unit_done_id_i[u]] = 1'b0;
    end
    // The new ID is free, so it can never collide with a done in the same cycle
    if (issue.accept) running_d[issue.unit][next_id_o] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= '0;
    end else begin
      running_q <= running_d;
    end
  end

endmodule : insn_tracker

//--- unit_queue_counters.sv
// Per-unit instruction queue occupancy counters, producing the ready vector for the accept decision
`timescale 1ns/1ns

module unit_queue_counters (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  seq_issue_if.sink                    issue,
  input  logic [seq_pkg::NR_UNITS-1:0] unit_done_i,
  output logic [seq_pkg::NR_UNITS-1:0] unit_ready_o
);

  import seq_pkg::*;

  // Occupancy of each unit queue
  logic [NR_UNITS-1:0][CNT_W-1:0] cnt_d, cnt_q;
  // Count enables with one bit per unit
  logic [NR_UNITS-1:0] cnt_up, cnt_down;

  ////////////////////////////////////////
  // Up/down control
  ////////////////////////////////////////

  always_comb begin
    for (int unsigned u = 0; u < NR_UNITS; u++) begin
      // An accepted instruction enters the queue of its target unit
      cnt_up[u]   = issue.accept && (issue.unit == u[UNIT_W-1:0]);
      // A done leaves the queue of the reporting unit
      cnt_down[u] = unit_done_i[u];
    end
  end

  always_comb begin
    cnt_d = cnt_q;
    for (int unsigned u = 0; u < NR_UNITS; u++) begin
      // Enter and leave together keep the occupancy unchanged
      if (cnt_up[u] && !cnt_down[u]) begin
        cnt_d[u] = cnt_q[u] + CNT_W'(1);
      end else if (cnt_down[u] && !cnt_up[u]) begin
        cnt_d[u] = cnt_q[u] - CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // A unit takes another instruction while its queue has room
  always_comb begin
    for (int unsigned u = 0; u < NR_UNITS; u++) begin
      unit_ready_o[u] = cnt_q[u] < QUEUE_DEPTH[u];
    end
  end

endmodule : unit_queue_counters

//--- vreg_scoreboard.sv
// Register read and write lists that yield RAW, WAR and WAW hazard vectors and the hazard table
`timescale 1ns/1ns

module vreg_scoreboard (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  seq_issue_if.sink                                           issue,
  input  logic [seq_pkg::VID_W-1:0]                           next_id_i,
  input  logic [seq_pkg::NR_VINSN-1:0]                        running_i,
  output logic [seq_pkg::NR_VINSN-1:0]                        hazard_vs1_o,
  output logic [seq_pkg::NR_VINSN-1:0]                        hazard_vs2_o,
  output logic [seq_pkg::NR_VINSN-1:0]                        hazard_vd_o,
  output logic [seq_pkg::NR_VINSN-1:0][seq_pkg::NR_VINSN-1:0] hazard_table_o
);

  import seq_pkg::*;

  // Last writer and last reader of every register
  logic [NR_VREGS-1:0][VID_W-1:0] wr_vid_d, wr_vid_q;
  logic [NR_VREGS-1:0][VID_W-1:0] rd_vid_d, rd_vid_q;
  logic [NR_VREGS-1:0]            wr_vld_d, wr_vld_q;
  logic [NR_VREGS-1:0]            rd_vld_d, rd_vld_q;
  // Entries whose owner is still in flight
  logic [NR_VREGS-1:0]            wr_live, rd_live;

  // Row N lists the instructions that instruction N depends on
  logic [NR_VINSN-1:0][NR_VINSN-1:0] haz_table_d, haz_table_q;

  ////////////////////////////////////////
  // Hazard lookup
  ////////////////////////////////////////

  // An entry only counts while its ID runs so that a reused ID inherits no old hazards
  always_comb begin
    for (int unsigned v = 0; v < NR_VREGS; v++) begin
      wr_live[v] = wr_vld_q[v] & running_i[wr_vid_q[v]];
      rd_live[v] = rd_vld_q[v] & running_i[rd_vid_q[v]];
    end
  end

  always_comb begin
    hazard_vs1_o = '0;
    hazard_vs2_o = '0;
    hazard_vd_o  = '0;
    // RAW on the sources
    if (issue.use_vs1 && wr_live[issue.vs1]) hazard_vs1_o[wr_vid_q[issue.vs1]] = 1'b1;
    if (issue.use_vs2 && wr_live[issue.vs2]) hazard_vs2_o[wr_vid_q[issue.vs2]] = 1'b1;
    // WAW and WAR both land on the destination vector
    if (issue.use_vd) begin
      if (wr_live[issue.vd]) hazard_vd_o[wr_vid_q[issue.vd]] = 1'b1;
      if (rd_live[issue.vd]) hazard_vd_o[rd_vid_q[issue.vd]] = 1'b1;
    end
  end

  ////////////////////////////////////////
  // List and table update
  ////////////////////////////////////////

  always_comb begin
    // Retire entries of finished instructions
    wr_vld_d    = wr_live;
    rd_vld_d    = rd_live;
    wr_vid_d    = wr_vid_q;
    rd_vid_d    = rd_vid_q;
    haz_table_d = haz_table_q;

    if (issue.accept) begin
      if (issue.use_vd) begin
        wr_vid_d[issue.vd] = next_id_i;
        wr_vld_d[issue.vd] = 1'b1;
      end
      if (issue.use_vs1) begin
        rd_vid_d[issue.vs1] = next_id_i;
        rd_vld_d[issue.vs1] = 1'b1;
      end
      if (issue.use_vs2) begin
        rd_vid_d[issue.vs2] = next_id_i;
        rd_vld_d[issue.vs2] = 1'b1;
      end
      haz_table_d[next_id_i] = hazard_vs1_o | hazard_vs2_o | hazard_vd_o;
    end

    // Drop the columns of IDs that have finished
    for (int unsigned r = 0; r < NR_VINSN; r++) begin
      haz_table_d[r] &= running_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_vld_q    <= '0;
      rd_vld_q    <= '0;
      wr_vid_q    <= '0;
      rd_vid_q    <= '0;
      haz_table_q <= '0;
    end else begin
      wr_vld_q    <= wr_vld_d;
      rd_vld_q    <= rd_vld_d;
      wr_vid_q    <= wr_vid_d;
      rd_vid_q    <= rd_vid_d;
      haz_table_q <= haz_table_d;
    end
  end

  assign hazard_table_o = haz_table_q;

endmodule : vreg_scoreboard

//--- issue_ctrl.sv
// Dispatcher accept decision and the registered issue request broadcast to the execution units
`timescale 1ns/1ns

module issue_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Dispatcher side
  input  logic                         req_valid_i,
  input  logic [seq_pkg::UNIT_W-1:0]   req_unit_i,
  input  logic [seq_pkg::VREG_W-1:0]   req_vs1_i,
  input  logic                         req_use_vs1_i,
  input  logic [seq_pkg::VREG_W-1:0]   req_vs2_i,
  input  logic                         req_use_vs2_i,
  input  logic [seq_pkg::VREG_W-1:0]   req_vd_i,
  input  logic                         req_use_vd_i,
  output logic                         req_ready_o,
  // Bookkeeping results
  input  logic [seq_pkg::VID_W-1:0]    next_id_i,
  input  logic                         id_full_i,
  input  logic [seq_pkg::NR_UNITS-1:0] unit_ready_i,
  input  logic [seq_pkg::NR_VINSN-1:0] hazard_vs1_i,
  input  logic [seq_pkg::NR_VINSN-1:0] hazard_vs2_i,
  input  logic [seq_pkg::NR_VINSN-1:0] hazard_vd_i,
  seq_issue_if.ctrl                    issue,
  // Issue request to the units
  output logic                         pe_req_valid_o,
  output logic [seq_pkg::VID_W-1:0]    pe_req_id_o,
  output logic [seq_pkg::UNIT_W-1:0]   pe_req_unit_o,
  output logic [seq_pkg::VREG_W-1:0]   pe_req_vd_o,
  output logic [seq_pkg::NR_VINSN-1:0] pe_hazard_vs1_o,
  output logic [seq_pkg::NR_VINSN-1:0] pe_hazard_vs2_o,
  output logic [seq_pkg::NR_VINSN-1:0] pe_hazard_vd_o
);

  logic accept;

  ////////////////////////////////////////
  // Accept decision
  ////////////////////////////////////////

  // Ready depends only on sequencer state, never on valid
  assign req_ready_o = !id_full_i && unit_ready_i[req_unit_i];
  assign accept      = req_valid_i && req_ready_o;

  // The fields follow the dispatcher every cycle so the scoreboard can look them up
  assign issue.accept  = accept;
  assign issue.unit    = req_unit_i;
  assign issue.vs1     = req_vs1_i;
  assign issue.use_vs1 = req_use_vs1_i;
  assign issue.vs2     = req_vs2_i;
  assign issue.use_vs2 = req_use_vs2_i;
  assign issue.vd      = req_vd_i;
  assign issue.use_vd  = req_use_vd_i;

  ////////////////////////////////////////
  // Issue request register
  ////////////////////////////////////////

  // Valid is a one-cycle pulse, the units never refuse it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_req_valid_o <= 1'b0;
    end else begin
      pe_req_valid_o <= accept;
    end
  end

  // Unused operands carry no hazard so the units do not wait on them
  always_ff @(posedge clk_i) begin
    if (accept) begin
      pe_req_id_o     <= next_id_i;
      pe_req_unit_o   <= req_unit_i;
      pe_req_vd_o     <= req_vd_i;
      pe_hazard_vs1_o <= req_use_vs1_i ? hazard_vs1_i : '0;
      pe_hazard_vs2_o <= req_use_vs2_i ? hazard_vs2_i : '0;
      pe_hazard_vd_o  <= req_use_vd_i ? hazard_vd_i : '0;
    end
  end

endmodule : issue_ctrl

//--- vector_sequencer.sv
// Vector instruction sequencer top level, connecting issue control, ID tracking, counters and scoreboard
`timescale 1ns/1ns

module vector_sequencer (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  // Dispatcher
  input  logic                                               req_valid_i,
  input  logic [seq_pkg::UNIT_W-1:0]                         req_unit_i,
  input  logic [seq_pkg::VREG_W-1:0]                         req_vs1_i,
  input  logic                                               req_use_vs1_i,
  input  logic [seq_pkg::VREG_W-1:0]                         req_vs2_i,
  input  logic                                               req_use_vs2_i,
  input  logic [seq_pkg::VREG_W-1:0]                         req_vd_i,
  input  logic                                               req_use_vd_i,
  output logic                                               req_ready_o,
  // Completion reports, one per unit
  input  logic [seq_pkg::NR_UNITS-1:0]                       unit_done_i,
  input  logic [seq_pkg::NR_UNITS-1:0][seq_pkg::VID_W-1:0]   unit_done_id_i,
  // Issue request to the units
  output logic                                               pe_req_valid_o,
  output logic [seq_pkg::VID_W-1:0]                          pe_req_id_o,
  output logic [seq_pkg::UNIT_W-1:0]                         pe_req_unit_o,
  output logic [seq_pkg::VREG_W-1:0]                         pe_req_vd_o,
  output logic [seq_pkg::NR_VINSN-1:0]                       pe_hazard_vs1_o,
  output logic [seq_pkg::NR_VINSN-1:0]                       pe_hazard_vs2_o,
  output logic [seq_pkg::NR_VINSN-1:0]                       pe_hazard_vd_o,
  // Status
  output logic [seq_pkg::NR_VINSN-1:0]                       vinsn_running_o,
  output logic [seq_pkg::NR_VINSN-1:0][seq_pkg::NR_VINSN-1:0] hazard_table_o,
  output logic                                               idle_o
);

  import seq_pkg::*;

  logic [VID_W-1:0]    next_id;
  logic                id_full;
  logic [NR_UNITS-1:0] unit_ready;
  logic [NR_VINSN-1:0] hazard_vs1, hazard_vs2, hazard_vd;

  // Accept event shared by all bookkeeping blocks
  seq_issue_if issue ();

  issue_ctrl i_issue_ctrl (
    .clk_i, .rst_ni,
    .req_valid_i, .req_unit_i, .req_vs1_i, .req_use_vs1_i,
    .req_vs2_i, .req_use_vs2_i, .req_vd_i, .req_use_vd_i, .req_ready_o,
    .next_id_i    (next_id),
    .id_full_i    (id_full),
    .unit_ready_i (unit_ready),
    .hazard_vs1_i (hazard_vs1),
    .hazard_vs2_i (hazard_vs2),
    .hazard_vd_i  (hazard_vd),
    .issue        (issue),
    .pe_req_valid_o, .pe_req_id_o, .pe_req_unit_o, .pe_req_vd_o,
    .pe_hazard_vs1_o, .pe_hazard_vs2_o, .pe_hazard_vd_o
  );

  insn_tracker i_insn_tracker (
    .clk_i, .rst_ni,
    .issue          (issue),
    .unit_done_i, .unit_done_id_i,
    .next_id_o      (next_id),
    .id_full_o      (id_full),
    .running_o      (vinsn_running_o),
    .idle_o
  );

  unit_queue_counters i_unit_queue_counters (
    .clk_i, .rst_ni,
    .issue        (issue),
    .unit_done_i,
    .unit_ready_o (unit_ready)
  );

  // Hazards are looked up against the running state of the previous edge
  vreg_scoreboard i_vreg_scoreboard (
    .clk_i, .rst_ni,
    .issue          (issue),
    .next_id_i      (next_id),
    .running_i      (vinsn_running_o),
    .hazard_vs1_o   (hazard_vs1),
    .hazard_vs2_o   (hazard_vs2),
    .hazard_vd_o    (hazard_vd),
    .hazard_table_o
  );

endmodule : vector_sequencer

//--- vector_sequencer_chk.sv
// Concurrent checks on the sequencer handshake and issue request, bound into the top level by the testbench
`timescale 1ns/1ns

module vector_sequencer_chk (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         req_valid_i,
  input logic                         req_ready_i,
  input logic                         pe_req_valid_i,
  input logic                         id_full_i,
  input logic [seq_pkg::NR_VINSN-1:0] running_i,
  input logic                         idle_i
);

  logic accept;

  assign accept = req_valid_i && req_ready_i;

  ////////////////////////////////////////
  // Issue request timing
  ////////////////////////////////////////

  // Every accept is followed by exactly one request cycle
  issue_after_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |=> pe_req_valid_i)
    else $error("Issue request missing in the cycle after an accept");

  no_issue_without_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !accept |=> !pe_req_valid_i)
    else $error("Issue request without a preceding accept");

  ////////////////////////////////////////
  // Status consistency
  ////////////////////////////////////////

  // With all IDs taken nothing may be accepted
  no_ready_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    id_full_i |-> !req_ready_i)
    else $error("Ready raised while all instruction IDs are in use");

  idle_matches_running: assert property (@(posedge clk_i) disable iff (!rst_ni)
    idle_i == (running_i == '0))
    else $error("Idle flag disagrees with the running vector");

endmodule : vector_sequencer_chk

//--- tb_vector_sequencer.sv
// Directed testbench for the vector sequencer, run as top level with the bound checker and a unit model
`timescale 1ns/1ns

module tb_vector_sequencer;

  import seq_pkg::*;

  localparam int CLK_PERIOD      = 20;
  localparam int NR_TESTS        = 5;
  localparam int CYCLES_PER_TEST = 100;
  localparam int TIMEOUT_NS      = NR_TESTS * CYCLES_PER_TEST * CLK_PERIOD;
  localparam logic [31:0] LCG_SEED = 32'h6495;
  // Queue depths of ALU, MUL, LOAD and STORE
  localparam int UNIT_DEPTH [NR_UNITS] = '{4, 2, 2, 2};

  logic                               clk_i, rst_ni;
  logic                               req_valid_i, req_ready_o;
  logic [UNIT_W-1:0]                  req_unit_i;
  logic [VREG_W-1:0]                  req_vs1_i, req_vs2_i, req_vd_i;
  logic                               req_use_vs1_i, req_use_vs2_i, req_use_vd_i;
  logic [NR_UNITS-1:0]                unit_done_i;
  logic [NR_UNITS-1:0][VID_W-1:0]     unit_done_id_i;
  logic                               pe_req_valid_o;
  logic [VID_W-1:0]                   pe_req_id_o;
  logic [UNIT_W-1:0]                  pe_req_unit_o;
  logic [VREG_W-1:0]                  pe_req_vd_o;
  logic [NR_VINSN-1:0]                pe_hazard_vs1_o, pe_hazard_vs2_o, pe_hazard_vd_o;
  logic [NR_VINSN-1:0]                vinsn_running_o;
  logic [NR_VINSN-1:0][NR_VINSN-1:0]  hazard_table_o;
  logic                               idle_o;

  // Reference model of running IDs, unit queues and register lists
  logic [NR_VINSN-1:0] ref_running;
  logic [UNIT_W-1:0]   ref_unit [NR_VINSN];
  int                  ref_cnt [NR_UNITS];
  logic [VID_W-1:0]    ref_wr_id [NR_VREGS];
  logic [VID_W-1:0]    ref_rd_id [NR_VREGS];
  logic                ref_wr_vld [NR_VREGS];
  logic                ref_rd_vld [NR_VREGS];
  logic [NR_VREGS-1:0] used_vregs;
  logic [31:0]         lcg_state;
  int                  errors;
  int                  checks;

  vector_sequencer dut0 (.*);

  bind vector_sequencer vector_sequencer_chk chk0 (
    .clk_i, .rst_ni, .req_valid_i,
    .req_ready_i    (req_ready_o),
    .pe_req_valid_i (pe_req_valid_o),
    .id_full_i      (id_full),
    .running_i      (vinsn_running_o),
    .idle_i         (idle_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Ends a run that hangs on a missing handshake
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("RESULT: FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Higher bits of the LCG are better distributed than the low ones
  function automatic logic [VREG_W-1:0] random_vreg();
    logic [31:0] r;
    r = lcg_next();
    return r[20:16];
  endfunction

  // Register not yet used in the current test
  function automatic logic [VREG_W-1:0] fresh_vreg();
    logic [VREG_W-1:0] v;
    v = random_vreg();
    while (used_vregs[v]) v = random_vreg();
    used_vregs[v] = 1'b1;
    return v;
  endfunction

  function automatic logic [VID_W-1:0] lowest_free_id();
    for (int i = 0; i < NR_VINSN; i++) begin
      if (!ref_running[i]) return VID_W'(i);
    end
    return '0;
  endfunction

  function automatic logic [NR_VINSN-1:0] id_bit(input logic [VID_W-1:0] id);
    id_bit = '0;
    id_bit[id] = 1'b1;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic idle_cycle();
    @(negedge clk_i);
  endtask

  // Offers one instruction and checks ready, the issue request and the bookkeeping
  task automatic send_insn(input logic [UNIT_W-1:0] unit,
                           input logic [VREG_W-1:0] vs1, input logic use_vs1,
                           input logic [VREG_W-1:0] vs2, input logic use_vs2,
                           input logic [VREG_W-1:0] vd, input logic use_vd,
                           output logic [VID_W-1:0] id);
    logic                exp_ready;
    logic [NR_VINSN-1:0] exp_vs1, exp_vs2, exp_vd;
    id        = lowest_free_id();
    exp_ready = !(&ref_running) && (ref_cnt[unit] < UNIT_DEPTH[unit]);
    exp_vs1   = '0;
    exp_vs2   = '0;
    exp_vd    = '0;
    // RAW on each source and WAW or WAR on the destination
    if (use_vs1 && ref_wr_vld[vs1]) exp_vs1[ref_wr_id[vs1]] = 1'b1;
    if (use_vs2 && ref_wr_vld[vs2]) exp_vs2[ref_wr_id[vs2]] = 1'b1;
    if (use_vd && ref_wr_vld[vd]) exp_vd[ref_wr_id[vd]] = 1'b1;
    if (use_vd && ref_rd_vld[vd]) exp_vd[ref_rd_id[vd]] = 1'b1;

    @(negedge clk_i);
    req_valid_i   = 1'b1;
    req_unit_i    = unit;
    req_vs1_i     = vs1;
    req_use_vs1_i = use_vs1;
    req_vs2_i     = vs2;
    req_use_vs2_i = use_vs2;
    req_vd_i      = vd;
    req_use_vd_i  = use_vd;
    // Ready is combinational and settles well away from both edges
    #(CLK_PERIOD / 4);
    check_value("req_ready_o", 64'(req_ready_o), 64'(exp_ready));
    @(negedge clk_i);
    req_valid_i = 1'b0;
    check_value("pe_req_valid_o", 64'(pe_req_valid_o), 64'(exp_ready));
    if (exp_ready) begin
      check_value("pe_req_id_o", 64'(pe_req_id_o), 64'(id));
      check_value("pe_req_unit_o", 64'(pe_req_unit_o), 64'(unit));
      check_value("pe_req_vd_o", 64'(pe_req_vd_o), 64'(vd));
      check_value("pe_hazard_vs1_o", 64'(pe_hazard_vs1_o), 64'(exp_vs1));
      check_value("pe_hazard_vs2_o", 64'(pe_hazard_vs2_o), 64'(exp_vs2));
      check_value("pe_hazard_vd_o", 64'(pe_hazard_vd_o), 64'(exp_vd));
      // The table row of the new ID merges all three vectors
      check_value("hazard_table_o row", 64'(hazard_table_o[id]),
                  64'(exp_vs1 | exp_vs2 | exp_vd));
      ref_running[id] = 1'b1;
      ref_unit[id]    = unit;
      ref_cnt[unit]++;
      if (use_vd) begin
        ref_wr_id[vd]  = id;
        ref_wr_vld[vd] = 1'b1;
      end
      if (use_vs1) begin
        ref_rd_id[vs1]  = id;
        ref_rd_vld[vs1] = 1'b1;
      end
      if (use_vs2) begin
        ref_rd_id[vs2]  = id;
        ref_rd_vld[vs2] = 1'b1;
      end
    end
    check_value("vinsn_running_o", 64'(vinsn_running_o), 64'(ref_running));
  endtask

  // Unit model that sends one done pulse for an ID from the unit that runs it
  task automatic report_done(input logic [VID_W-1:0] id);
    logic [UNIT_W-1:0] u;
    u = ref_unit[id];
    @(negedge clk_i);
    unit_done_i[u]    = 1'b1;
    unit_done_id_i[u] = id;
    @(negedge clk_i);
    unit_done_i    = '0;
    unit_done_id_i = '0;
    ref_running[id] = 1'b0;
    ref_cnt[u]--;
    for (int v = 0; v < NR_VREGS; v++) begin
      if (ref_wr_vld[v] && ref_wr_id[v] == id) ref_wr_vld[v] = 1'b0;
      if (ref_rd_vld[v] && ref_rd_id[v] == id) ref_rd_vld[v] = 1'b0;
    end
    check_value("vinsn_running_o", 64'(vinsn_running_o), 64'(ref_running));
    check_value("idle_o", 64'(idle_o), 64'(ref_running == '0));
  endtask

  task automatic drain_running();
    for (int i = 0; i < NR_VINSN; i++) begin
      if (ref_running[i]) report_done(VID_W'(i));
    end
  endtask

  task automatic check_column_clear(input logic [VID_W-1:0] id);
    logic [NR_VINSN-1:0] column;
    for (int r = 0; r < NR_VINSN; r++) column[r] = hazard_table_o[r][id];
    check_value("hazard_table_o column", 64'(column), 64'd0);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic single_insn_flow();
    logic [VID_W-1:0] id;
    check_value("idle_o", 64'(idle_o), 64'd1);
    check_value("req_ready_o", 64'(req_ready_o), 64'd1);
    check_value("pe_req_valid_o", 64'(pe_req_valid_o), 64'd0);
    check_value("hazard_table_o", 64'(hazard_table_o), 64'd0);
    send_insn(UNIT_ALU, 5'd1, 1'b1, 5'd2, 1'b1, 5'd3, 1'b1, id);
    check_value("pe_req_id_o of first insn", 64'(pe_req_id_o), 64'd0);
    // The request must be gone one cycle later
    idle_cycle();
    check_value("pe_req_valid_o", 64'(pe_req_valid_o), 64'd0);
    report_done(id);
  endtask

  task automatic hazard_detection();
    logic [VREG_W-1:0] a, b, c, d, e, f, g, h, k;
    logic [VID_W-1:0]  id_a, id_b, id_c, id_d, id_e;
    used_vregs = '0;
    a = fresh_vreg();
    b = fresh_vreg();
    c = fresh_vreg();
    d = fresh_vreg();
    e = fresh_vreg();
    f = fresh_vreg();
    g = fresh_vreg();
    h = fresh_vreg();
    k = fresh_vreg();
    send_insn(UNIT_ALU, a, 1'b1, b, 1'b1, c, 1'b1, id_a);
    // Reads the destination of the first one
    send_insn(UNIT_ALU, c, 1'b1, d, 1'b1, e, 1'b1, id_b);
    check_value("RAW hazard_vs1", 64'(pe_hazard_vs1_o), 64'(id_bit(id_a)));
    // Overwrites a register the first one still reads, and reads its destination
    send_insn(UNIT_MUL, f, 1'b1, c, 1'b1, b, 1'b1, id_c);
    check_value("RAW hazard_vs2", 64'(pe_hazard_vs2_o), 64'(id_bit(id_a)));
    check_value("WAR hazard_vd", 64'(pe_hazard_vd_o), 64'(id_bit(id_a)));
    send_insn(UNIT_LOAD, g, 1'b0, g, 1'b0, e, 1'b1, id_d);
    check_value("WAW hazard_vd", 64'(pe_hazard_vd_o), 64'(id_bit(id_b)));
    // Untouched registers give no hazards at all
    send_insn(UNIT_STORE, h, 1'b1, k, 1'b1, g, 1'b0, id_e);
    check_value("independent hazards",
                64'({pe_hazard_vs1_o, pe_hazard_vs2_o, pe_hazard_vd_o}), 64'd0);
    drain_running();
  endtask

  task automatic hazard_table_update();
    logic [VREG_W-1:0] x, y, z;
    logic [VID_W-1:0]  id_a, id_b;
    used_vregs = '0;
    x = fresh_vreg();
    y = fresh_vreg();
    z = fresh_vreg();
    send_insn(UNIT_ALU, y, 1'b1, z, 1'b0, x, 1'b1, id_a);
    send_insn(UNIT_MUL, x, 1'b1, z, 1'b1, y, 1'b1, id_b);
    check_value("dependent row", 64'(hazard_table_o[id_b]), 64'(id_bit(id_a)));
    report_done(id_a);
    // The column follows the running state one cycle later
    idle_cycle();
    check_column_clear(id_a);
    drain_running();
  endtask

  task automatic queue_backpressure();
    logic [VID_W-1:0] m1, m2, blocked, alu, m3;
    send_insn(UNIT_MUL, random_vreg(), 1'b1, random_vreg(), 1'b1, random_vreg(), 1'b1, m1);
    send_insn(UNIT_MUL, random_vreg(), 1'b1, random_vreg(), 1'b1, random_vreg(), 1'b1, m2);
    send_insn(UNIT_MUL, random_vreg(), 1'b1, random_vreg(), 1'b1, random_vreg(), 1'b1, blocked);
    // Other units are not held up by the full MUL queue
    send_insn(UNIT_ALU, random_vreg(), 1'b1, random_vreg(), 1'b1, random_vreg(), 1'b1, alu);
    report_done(m1);
    send_insn(UNIT_MUL, random_vreg(), 1'b1, random_vreg(), 1'b1, random_vreg(), 1'b1, m3);
    check_value("pe_req_unit_o after MUL done", 64'(pe_req_unit_o), 64'(UNIT_MUL));
    drain_running();
  endtask

  task automatic id_exhaustion_reuse();
    logic [VID_W-1:0] id;
    logic [UNIT_W-1:0] unit;
    for (int i = 0; i < NR_VINSN; i++) begin
      unit = (i < 4) ? UNIT_ALU : (i < 6) ? UNIT_MUL : UNIT_LOAD;
      send_insn(unit, random_vreg(), 1'b1, random_vreg(), 1'b1, random_vreg(), 1'b1, id);
    end
    check_value("vinsn_running_o when full", 64'(vinsn_running_o), 64'hff);
    // No ID left, so even the empty STORE queue must wait
    send_insn(UNIT_STORE, random_vreg(), 1'b1, random_vreg(), 1'b1, random_vreg(), 1'b0, id);
    report_done(3'd5);
    send_insn(UNIT_STORE, random_vreg(), 1'b1, random_vreg(), 1'b1, random_vreg(), 1'b0, id);
    check_value("pe_req_id_o after reuse", 64'(pe_req_id_o), 64'd5);
    drain_running();
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rst_ni         = 1'b0;
    req_valid_i    = 1'b0;
    req_unit_i     = UNIT_ALU;
    req_vs1_i      = '0;
    req_use_vs1_i  = 1'b0;
    req_vs2_i      = '0;
    req_use_vs2_i  = 1'b0;
    req_vd_i       = '0;
    req_use_vd_i   = 1'b0;
    unit_done_i    = '0;
    unit_done_id_i = '0;
    ref_running    = '0;
    used_vregs     = '0;
    lcg_state      = LCG_SEED;
    errors         = 0;
    checks         = 0;
    for (int i = 0; i < NR_VINSN; i++) ref_unit[i] = '0;
    for (int u = 0; u < NR_UNITS; u++) ref_cnt[u] = 0;
    for (int v = 0; v < NR_VREGS; v++) begin
      ref_wr_id[v]  = '0;
      ref_rd_id[v]  = '0;
      ref_wr_vld[v] = 1'b0;
      ref_rd_vld[v] = 1'b0;
    end
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    single_insn_flow();
    hazard_detection();
    hazard_table_update();
    queue_backpressure();
    id_exhaustion_reuse();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule : tb_vector_sequencer

//--- verilog.f
seq_pkg.sv
seq_issue_if.sv
insn_tracker.sv
unit_queue_counters.sv
vreg_scoreboard.sv
issue_ctrl.sv
vector_sequencer.sv
vector_sequencer_chk.sv
tb_vector_sequencer.sv

//--- Makefile
# Verilator flow for the vector sequencer testbench

VERILATOR ?= verilator
TOP       ?= tb_vector_sequencer
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SHELL := /bin/bash
SRCS  := $(shell grep -v '^+' $(FILELIST))
BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# A failing assertion stops the binary, a failing check prints the fail line
sim: $(BIN)
	set -o pipefail; ./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
